/* Bender.yml */
package:
  name: video_sync

export_include_dirs:
  - include

sources:
  - files:
      - verilog/video_sync_pkg.sv
      - verilog/sync_polarity_fix.sv
      - verilog/sync_combiner.sv
      - verilog/sync_cmd_decoder.sv
      - verilog/video_sync_top.sv
  - target: test
    files:
      - verification/tb_video_sync.sv

/* flist.f */
+incdir+include
verilog/video_sync_pkg.sv
verilog/sync_polarity_fix.sv
verilog/sync_combiner.sv
verilog/sync_cmd_decoder.sv
verilog/video_sync_top.sv
verification/tb_video_sync.sv

/* include/video_sync_defines.svh */
////////////////////////////////////////
// video sync conditioning
// shared widths, host command codes and
// configuration bit positions
////////////////////////////////////////

`ifndef VIDEO_SYNC_DEFINES_SVH
`define VIDEO_SYNC_DEFINES_SVH

// phase and line counters saturate at all ones
`define VS_CNT_W 16

// host bus word
`define VS_IO_W 16

////////////////////////////////////////
// host commands
////////////////////////////////////////

// configuration write
`define VS_CMD_CFG 8'h01

// composite sync enable in the config word
`define VS_CFG_CSYNC_BIT 3

`endif

/* verification/tb_video_sync.sv */
////////////////////////////////////////
// video sync conditioning testbench
// directed tests for polarity fix,
// composite sync and host commands
////////////////////////////////////////

`timescale 1ns/1ps

`include "video_sync_defines.svh"

module tb_video_sync;

	localparam int LINE = 96;
	localparam int WAIT_LIMIT = 4 * LINE;
	localparam video_sync_pkg::io_word_t CSYNC_ON = 16'h0001 << `VS_CFG_CSYNC_BIT;

	logic clk_sys;
	logic resetd;
	logic i_hsync;
	logic i_vsync;
	logic i_io_sel;
	logic i_io_strobe;
	video_sync_pkg::io_word_t i_io_din;
	logic o_hs;
	logic o_vs;

	logic [31:0] lfsr;
	int checks;
	int errors;
	int test_errors;

	video_sync_top uut (
		.i_clk_sys   (clk_sys),
		.i_resetd    (resetd),
		.i_hsync     (i_hsync),
		.i_vsync     (i_vsync),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_hs        (o_hs),
		.o_vs        (o_vs)
	);

	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// pulse width 4 to 19, one lfsr step per bit
	task pick_width(output int w);
		int i;
		begin
			w = 4;
			for (i = 0; i < 4; i++) begin
				lfsr = lfsr_next(lfsr);
				w = w + (int'(lfsr[0]) << i);
			end
		end
	endtask

	task check_value(input string name, input int exp, input int act);
		begin
			checks++;
			if (act != exp) begin
				errors++;
				test_errors++;
				$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			end
		end
	endtask

	task finish_test(input string name);
		begin
			$display("test %s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
				test_errors);
			test_errors = 0;
		end
	endtask

	// one line on hsync or vsync, pulse first
	task automatic drive_line(input logic on_vs, input int period, input int width,
		input logic active_low);
		int i;
		logic level;
		begin
			for (i = 0; i < period; i++) begin
				@(posedge clk_sys);
				level = (i < width) ^ active_low;
				if (on_vs) begin
					i_vsync <= level;
				end else begin
					i_hsync <= level;
				end
			end
		end
	endtask

	// high cycles over one period, starting at the next rising edge
	task automatic measure_high(input logic on_vs, input int period, output int cnt);
		int waited;
		logic prev;
		logic cur;
		logic found;
		begin
			waited = 0;
			found = 1'b0;
			prev = on_vs ? o_vs : o_hs;
			while (!found && waited < WAIT_LIMIT) begin
				@(negedge clk_sys);
				cur = on_vs ? o_vs : o_hs;
				found = (cur === 1'b1) && (prev !== 1'b1);
				prev = cur;
				waited++;
			end
			if (!found) begin
				errors++;
				test_errors++;
				cnt = -1;
				$display("timeout at %0t: %s did not rise within %0d cycles", $time,
					on_vs ? "o_vs" : "o_hs", WAIT_LIMIT);
			end else begin
				cnt = 1;
				repeat (period - 1) begin
					@(negedge clk_sys);
					if ((on_vs ? o_vs : o_hs) === 1'b1) begin
						cnt++;
					end
				end
			end
		end
	endtask

	// command word, optional data word, then deselect
	task write_cmd(input video_sync_pkg::io_word_t cmd, input video_sync_pkg::io_word_t data,
		input logic with_data);
		begin
			@(posedge clk_sys);
			i_io_sel <= 1'b1;
			@(posedge clk_sys);
			i_io_strobe <= 1'b1;
			i_io_din <= cmd;
			@(posedge clk_sys);
			i_io_strobe <= 1'b0;
			if (with_data) begin
				@(posedge clk_sys);
				i_io_strobe <= 1'b1;
				i_io_din <= data;
				@(posedge clk_sys);
				i_io_strobe <= 1'b0;
			end
			@(posedge clk_sys);
			i_io_sel <= 1'b0;
		end
	endtask

	// nine active low lines, vsync (active low) covers lines 4 to 6
	task run_frame(input int width, output int out_cnt, output int in_cnt);
		begin
			fork
				repeat (9) drive_line(1'b0, LINE, width, 1'b1);
				begin
					repeat (4 * LINE + 1) @(posedge clk_sys);
					i_vsync <= 1'b0;
					repeat (3 * LINE) @(posedge clk_sys);
					i_vsync <= 1'b1;
				end
				begin
					repeat (2 * LINE) @(negedge clk_sys);
					measure_high(1'b0, LINE, out_cnt);
				end
				begin
					repeat (5 * LINE) @(negedge clk_sys);
					measure_high(1'b0, LINE, in_cnt);
				end
			join
		end
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task test_reset_idle;
		int hs_cnt;
		int vs_cnt;
		begin
			hs_cnt = 0;
			vs_cnt = 0;
			repeat (2 * LINE) begin
				@(negedge clk_sys);
				if (o_hs !== 1'b0) begin
					hs_cnt++;
				end
				if (o_vs !== 1'b0) begin
					vs_cnt++;
				end
			end
			check_value("o_hs non-low cycles", 0, hs_cnt);
			check_value("o_vs non-low cycles", 0, vs_cnt);
			finish_test("reset idle");
		end
	endtask

	task test_active_high_hs;
		int w;
		int c0;
		int c1;
		begin
			pick_width(w);
			fork
				repeat (6) drive_line(1'b0, LINE, w, 1'b0);
				begin
					repeat (2 * LINE) @(negedge clk_sys);
					measure_high(1'b0, LINE, c0);
					measure_high(1'b0, LINE, c1);
				end
			join
			check_value("o_hs high cycles, line 2", w, c0);
			check_value("o_hs high cycles, line 3", w, c1);
			finish_test("active high hsync");
		end
	endtask

	task test_active_low;
		int w;
		int hs_cnt;
		int vs_cnt;
		begin
			pick_width(w);
			fork
				repeat (5) drive_line(1'b0, LINE, w, 1'b1);
				repeat (5) drive_line(1'b1, LINE, w, 1'b1);
				begin
					repeat (2 * LINE) @(negedge clk_sys);
					measure_high(1'b0, LINE, hs_cnt);
				end
				begin
					repeat (2 * LINE) @(negedge clk_sys);
					measure_high(1'b1, LINE, vs_cnt);
				end
			join
			check_value("o_hs high cycles", w, hs_cnt);
			check_value("o_vs high cycles", w, vs_cnt);
			finish_test("active low syncs");
		end
	endtask

	task test_composite;
		int w;
		int out_cnt;
		int in_cnt;
		begin
			write_cmd(`VS_CMD_CFG, CSYNC_ON, 1'b1);
			pick_width(w);
			run_frame(w, out_cnt, in_cnt);
			check_value("o_hs high cycles outside vsync", w, out_cnt);
			check_value("o_hs high cycles inside vsync", LINE - w, in_cnt);
			finish_test("composite sync");
		end
	endtask

	task test_decoder;
		int w;
		int out_cnt;
		int in_cnt;
		begin
			pick_width(w);
			// back to separate sync
			write_cmd(`VS_CMD_CFG, 16'h0000, 1'b1);
			run_frame(w, out_cnt, in_cnt);
			check_value("o_hs in vsync after cfg clear", w, in_cnt);
			// data for an unknown command
			write_cmd(16'h0002, CSYNC_ON, 1'b1);
			run_frame(w, out_cnt, in_cnt);
			check_value("o_hs in vsync after other code", w, in_cnt);
			// deselect drops the held cfg command, lone word is a new command
			write_cmd(`VS_CMD_CFG, 16'h0000, 1'b0);
			write_cmd(CSYNC_ON, 16'h0000, 1'b0);
			run_frame(w, out_cnt, in_cnt);
			check_value("o_hs in vsync after lone word", w, in_cnt);
			finish_test("command decoder");
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		resetd = 1'b1;
		i_hsync = 1'b0;
		i_vsync = 1'b0;
		i_io_sel = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din = '0;
		lfsr = 32'hccdfc72c;
		checks = 0;
		errors = 0;
		test_errors = 0;
		repeat (8) @(posedge clk_sys);
		resetd <= 1'b0;

		test_reset_idle();
		test_active_high_hs();
		test_active_low();
		test_composite();
		test_decoder();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* verilog/sync_cmd_decoder.sv */
////////////////////////////////////////
// host command decoder
// takes strobed 16 bit host words and
// loads the configuration register
////////////////////////////////////////

`timescale 1ns/1ps

`include "video_sync_defines.svh"

module sync_cmd_decoder (
	input  logic                      i_clk_sys,
	input  logic                      i_resetd,
	input  logic                      i_io_sel,
	input  logic                      i_io_strobe,
	input  video_sync_pkg::io_word_t  i_io_din,
	output logic                      o_csync_en
);

	video_sync_pkg::dec_state_t state;

	// command held for the following data words
	video_sync_pkg::cmd_code_t cmd_q;

	// configuration register
	video_sync_pkg::io_word_t cfg_q;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			state <= video_sync_pkg::DEC_IDLE;
			cmd_q <= '0;
			cfg_q <= '0;
		end else if (!i_io_sel) begin
			// deselect drops any pending command
			state <= video_sync_pkg::DEC_IDLE;
			cmd_q <= '0;
		end else if (i_io_strobe) begin
			case (state)
				video_sync_pkg::DEC_IDLE: begin
					// first word after select is the command
					cmd_q <= i_io_din[7:0];
					state <= video_sync_pkg::DEC_DATA;
				end
				video_sync_pkg::DEC_DATA: begin
					// last data word wins
					if (cmd_q == `VS_CMD_CFG) begin
						cfg_q <= i_io_din;
					end
				end
				default: begin
					state <= video_sync_pkg::DEC_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// config fields
	////////////////////////////////////////

	assign o_csync_en = cfg_q[`VS_CFG_CSYNC_BIT];

endmodule

/* verilog/sync_combiner.sv */
////////////////////////////////////////
// sync combiner
// derives composite sync from hs and vs
// and selects separate or composite sync
// for the horizontal output
////////////////////////////////////////

`timescale 1ns/1ps

module sync_combiner (
	input  logic i_clk_sys,
	input  logic i_resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync_en,
	output logic o_hs,
	output logic o_vs
);

	// hs edge detect
	logic hs_d;
	logic hs_rise;
	logic hs_fall;

	// line timing measured from hs edges
	video_sync_pkg::sync_cnt_t line_cnt;
	video_sync_pkg::sync_cnt_t pulse_len;
	video_sync_pkg::sync_cnt_t line_len;

	// composite sync state and its next value
	logic comp_q;
	logic comp_d;

	assign hs_rise = i_hs & ~hs_d;
	assign hs_fall = ~i_hs & hs_d;

	////////////////////////////////////////
	// composite sync
	////////////////////////////////////////

	// outside vsync the composite is plain hs
	// inside vsync it drops for one pulse width ahead of each hs rise
	always_comb begin
		comp_d = comp_q;
		if (!i_vs) begin
			comp_d = i_hs;
		end else if (hs_rise) begin
			comp_d = 1'b1;
		end else if (!i_hs && (line_cnt == line_len)) begin
			comp_d = 1'b0;
		end
	end

	////////////////////////////////////////
	// counters and output stage
	////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			hs_d      <= 1'b0;
			line_cnt  <= '0;
			pulse_len <= '0;
			line_len  <= '0;
			comp_q    <= 1'b0;
			o_hs      <= 1'b0;
			o_vs      <= 1'b0;
		end else begin
			hs_d <= i_hs;

			// edge cycle counts as the first cycle of the new phase
			if (hs_rise || hs_fall) begin
				line_cnt <= video_sync_pkg::sync_cnt_t'(1);
			end else if (line_cnt != '1) begin
				line_cnt <= line_cnt + 1'b1;
			end

			if (hs_fall) begin
				pulse_len <= line_cnt;
			end
			// remaining line is the low time minus one pulse
			if (hs_rise) begin
				line_len <= line_cnt - pulse_len;
			end

			comp_q <= comp_d;
			o_hs   <= i_csync_en ? comp_d : i_hs;
			o_vs   <= i_vs;
		end
	end

endmodule

/* verilog/sync_polarity_fix.sv */
////////////////////////////////////////
// sync polarity normalizer
// measures high and low phases of a sync
// line and inverts it when the high phase
// is longer, so the output is active high
////////////////////////////////////////

`timescale 1ns/1ps

module sync_polarity_fix (
	input  logic i_clk_sys,
	input  logic i_resetd,
	input  logic i_sync,
	output logic o_sync
);

	// two stage input synchronizer
	logic sync_q1;
	logic sync_q2;

	// phase measurement
	video_sync_pkg::sync_cnt_t phase_cnt;
	video_sync_pkg::sync_cnt_t high_len;
	video_sync_pkg::sync_cnt_t low_len;

	// set when the line idles high
	logic pol;

	logic sync_rise;
	logic sync_fall;

	assign sync_rise = sync_q1 & ~sync_q2;
	assign sync_fall = ~sync_q1 & sync_q2;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			sync_q1   <= 1'b0;
			sync_q2   <= 1'b0;
			phase_cnt <= '0;
			high_len  <= '0;
			low_len   <= '0;
			pol       <= 1'b0;
			o_sync    <= 1'b0;
		end else begin
			sync_q1 <= i_sync;
			sync_q2 <= sync_q1;

			// a rising edge closes a low phase and vice versa
			if (sync_rise) begin
				low_len <= phase_cnt;
			end
			if (sync_fall) begin
				high_len <= phase_cnt;
			end

			// restart on every edge, hold at all ones
			if (sync_rise || sync_fall) begin
				phase_cnt <= '0;
			end else if (phase_cnt != '1) begin
				phase_cnt <= phase_cnt + 1'b1;
			end

			pol    <= (high_len > low_len);
			o_sync <= sync_q2 ^ pol;
		end
	end

endmodule

/* verilog/video_sync_pkg.sv */
////////////////////////////////////////
// video sync shared types
// counter and host word vectors plus the
// command decoder state encoding
////////////////////////////////////////

`include "video_sync_defines.svh"

package video_sync_pkg;

	// phase length, line length and pulse length
	typedef logic [`VS_CNT_W-1:0] sync_cnt_t;

	// host word, also used for the config register
	typedef logic [`VS_IO_W-1:0] io_word_t;

	// low byte of a command word
	typedef logic [7:0] cmd_code_t;

	// decoder states
	// idle waits for a command word, data means a command is held
	typedef enum logic {
		DEC_IDLE = 1'b0,
		DEC_DATA = 1'b1
	} dec_state_t;

endpackage

/* verilog/video_sync_top.sv */
////////////////////////////////////////
// video sync conditioning top
// normalizes hsync and vsync polarity,
// then builds separate or composite sync
// as set by the host command decoder
////////////////////////////////////////

`timescale 1ns/1ps

module video_sync_top (
	input  logic                      i_clk_sys,
	input  logic                      i_resetd,
	input  logic                      i_hsync,
	input  logic                      i_vsync,
	input  logic                      i_io_sel,
	input  logic                      i_io_strobe,
	input  video_sync_pkg::io_word_t  i_io_din,
	output logic                      o_hs,
	output logic                      o_vs
);

	// active high syncs after polarity fix
	logic hs_fixed;
	logic vs_fixed;

	// composite enable from the config register
	logic csync_en;

	sync_polarity_fix u_hs_fix (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_sync    (i_hsync),
		.o_sync    (hs_fixed)
	);

	sync_polarity_fix u_vs_fix (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_sync    (i_vsync),
		.o_sync    (vs_fixed)
	);

	sync_combiner u_comb (
		.i_clk_sys  (i_clk_sys),
		.i_resetd   (i_resetd),
		.i_hs       (hs_fixed),
		.i_vs       (vs_fixed),
		.i_csync_en (csync_en),
		.o_hs       (o_hs),
		.o_vs       (o_vs)
	);

	sync_cmd_decoder u_dec (
		.i_clk_sys   (i_clk_sys),
		.i_resetd    (i_resetd),
		.i_io_sel    (i_io_sel),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_csync_en  (csync_en)
	);

endmodule
